// File: verilog/c16_mem_macros.svh
`ifndef C16_MEM_MACROS_SVH
`define C16_MEM_MACROS_SVH

// --------------------
// memory map
`define TAP_MEM_START    25'h0020000
`define TAP_VERSION_OFS  25'h000000c

// ioctl download indices
`define IDX_PRG          8'h01
`define IDX_TAP          8'h41

// slot pair of 16 cycles, upper bit is clkref
`define SLOT_BITS        4

// basic end pointers in zero page, low byte first
`define ZP_END_PTR0      16'h002d
`define ZP_END_PTR1      16'h002f
`define ZP_END_PTR2      16'h0031
`define ZP_END_PTR3      16'h009d

`endif

// File: verilog/c16_mem_pkg.sv
package c16_mem_pkg;

	typedef logic [7:0]  byte_t;
	typedef logic [15:0] word_t;
	typedef logic [15:0] cpu_addr_t;
	typedef logic [23:0] sd_addr_t;
	typedef logic [24:0] io_addr_t;

	// request from the c16 bus, levels follow cas
	typedef struct packed {
		cpu_addr_t addr;
		byte_t     wdata;
		logic      wr;
		logic      rd;
	} c16_req_t;

	// io side request, byte addressed
	typedef struct packed {
		io_addr_t addr;
		byte_t    wdata;
		logic     wr;
		logic     rd;
	} io_req_t;

	// word request towards the sdram
	typedef struct packed {
		sd_addr_t   addr;
		word_t      wdata;
		logic       we;
		logic       oe;
		logic [1:0] ds;
	} sd_req_t;

	typedef enum logic [2:0] {
		LD_IDLE,
		LD_ADDR_LO,
		LD_ADDR_HI,
		LD_DATA,
		LD_TAP
	} loader_state_t;

endpackage

// File: verilog/c16_bus_latch.sv
`timescale 1ns/1ns
`include "c16_mem_macros.svh"

module c16_bus_latch import c16_mem_pkg::*; (
	input  logic     clk28,
	input  logic     reset,
	input  logic     c16_ras_n_i,
	input  logic     c16_cas_n_i,
	input  logic     c16_rw_i,
	input  byte_t    c16_a_i,
	input  byte_t    c16_dout_i,
	output c16_req_t c16_req_o,
	output logic     clkref_o,
	output logic     slot_io_start_o,
	output logic     slot_c16_start_o
);

	logic ras_q;
	logic cas_q;
	logic clkref_q;
	logic ras_seen;
	logic ras_fall;
	logic cas_fall;
	logic [`SLOT_BITS-1:0] slot_cnt;
	byte_t a_lo;
	byte_t a_hi;

	assign ras_fall = ras_q & ~c16_ras_n_i;
	assign cas_fall = cas_q & ~c16_cas_n_i;

	always_ff @(posedge clk28) begin
		if (reset) begin
			ras_q <= 1'b1;
			cas_q <= 1'b1;
			clkref_q <= 1'b0;
			ras_seen <= 1'b0;
			slot_cnt <= '0;
		end else begin
			ras_q <= c16_ras_n_i;
			cas_q <= c16_cas_n_i;
			clkref_q <= clkref_o;
			// counter locks onto the ras phase of the c16
			if (ras_fall)
				slot_cnt <= '0;
			else
				slot_cnt <= slot_cnt + 1'b1;
			if (cas_fall)
				ras_seen <= 1'b0;
			if (ras_fall)
				ras_seen <= 1'b1;
		end
	end

	// row on ras, column on cas
	always_ff @(posedge clk28) begin
		if (ras_fall)
			a_lo <= c16_a_i;
		if (cas_fall)
			a_hi <= c16_a_i;
	end

	assign clkref_o = slot_cnt[`SLOT_BITS-1];
	assign slot_io_start_o = clkref_q & ~clkref_o;
	assign slot_c16_start_o = ~clkref_q & clkref_o;

	// levels start once the high byte is latched
	assign c16_req_o.addr = {a_hi, a_lo};
	assign c16_req_o.wdata = c16_dout_i;
	assign c16_req_o.wr = ~cas_q & ~c16_cas_n_i & ~c16_rw_i;
	assign c16_req_o.rd = ~cas_q & ~c16_cas_n_i & c16_rw_i;

	a_cas_after_ras: assert property (@(posedge clk28) disable iff (reset)
		cas_fall |-> ras_seen);

endmodule

// File: verilog/prg_loader.sv
`timescale 1ns/1ns
`include "c16_mem_macros.svh"

module prg_loader import c16_mem_pkg::*; (
	input  logic     clk28,
	input  logic     reset,
	input  logic     ioctl_wr_i,
	input  io_addr_t ioctl_addr_i,
	input  byte_t    ioctl_data_i,
	input  byte_t    ioctl_index_i,
	input  logic     ioctl_download_i,
	input  logic     slot_io_start_i,
	input  logic     slot_c16_start_i,
	output io_req_t  ld_req_o,
	output logic     prg_done_o,
	output io_addr_t tap_end_o,
	output logic [1:0] tap_version_o,
	output logic     tap_restart_o,
	output logic     c16_wait_o
);

	loader_state_t state;
	io_addr_t ld_addr;
	byte_t byte_buf;
	byte_t wdata;
	logic pend;
	logic wr_lvl;
	logic tap_mode;
	logic prg_dl;
	logic tap_dl;
	logic prg_dl_q;
	logic done_pend;

	assign prg_dl = ioctl_download_i && (ioctl_index_i == `IDX_PRG);
	assign tap_dl = ioctl_download_i && (ioctl_index_i == `IDX_TAP);

	always_ff @(posedge clk28) begin
		if (reset) begin
			state <= LD_IDLE;
			pend <= 1'b0;
			wr_lvl <= 1'b0;
			tap_mode <= 1'b0;
			prg_dl_q <= 1'b0;
			done_pend <= 1'b0;
			prg_done_o <= 1'b0;
			tap_end_o <= `TAP_MEM_START;
			tap_version_o <= 2'd0;
		end else begin
			prg_dl_q <= prg_dl;
			prg_done_o <= 1'b0;

			// --------------------
			// slot handling
			if (slot_io_start_i) begin
				wr_lvl <= pend;
				pend <= 1'b0;
				if (pend)
					wdata <= byte_buf;
			end
			if (slot_c16_start_i && wr_lvl) begin
				wr_lvl <= 1'b0;
				ld_addr <= ld_addr + 25'd1;
				if (tap_mode)
					tap_end_o <= ld_addr + 25'd1;
			end

			// --------------------
			// byte sequencing
			case (state)
				LD_IDLE: begin
					if (prg_dl) begin
						tap_mode <= 1'b0;
						state <= LD_ADDR_LO;
					end else if (tap_dl) begin
						tap_mode <= 1'b1;
						ld_addr <= `TAP_MEM_START;
						tap_end_o <= `TAP_MEM_START;
						state <= LD_TAP;
					end
				end
				LD_ADDR_LO: begin
					if (!ioctl_download_i)
						state <= LD_IDLE;
					else if (ioctl_wr_i) begin
						ld_addr[7:0] <= ioctl_data_i;
						state <= LD_ADDR_HI;
					end
				end
				LD_ADDR_HI: begin
					if (!ioctl_download_i)
						state <= LD_IDLE;
					else if (ioctl_wr_i) begin
						ld_addr[24:8] <= {9'd0, ioctl_data_i};
						state <= LD_DATA;
					end
				end
				LD_DATA, LD_TAP: begin
					if (!ioctl_download_i)
						state <= LD_IDLE;
					else if (ioctl_wr_i) begin
						// held until the next io slot
						pend <= 1'b1;
						byte_buf <= ioctl_data_i;
						if (state == LD_TAP && ioctl_addr_i == `TAP_VERSION_OFS)
							tap_version_o <= ioctl_data_i[1:0];
					end
				end
				default: state <= LD_IDLE;
			endcase

			// end pointer is final once the last write went out
			if (prg_dl_q && !prg_dl)
				done_pend <= 1'b1;
			else if (done_pend && !pend && !wr_lvl) begin
				done_pend <= 1'b0;
				prg_done_o <= 1'b1;
			end
		end
	end

	assign ld_req_o.addr = ld_addr;
	assign ld_req_o.wdata = wdata;
	assign ld_req_o.wr = wr_lvl;
	assign ld_req_o.rd = 1'b0;

	assign tap_restart_o = (state == LD_TAP) || (tap_mode && (pend || wr_lvl));
	assign c16_wait_o = prg_dl;

endmodule

// File: verilog/zp_shadow.sv
`timescale 1ns/1ns
`include "c16_mem_macros.svh"

module zp_shadow import c16_mem_pkg::*; (
	input  logic      clk28,
	input  logic      reset,
	input  c16_req_t  c16_req_i,
	input  logic      c16_cas_n_i,
	input  logic      prg_done_i,
	input  cpu_addr_t end_addr_i,
	input  byte_t     rd_byte_i,
	output byte_t     c16_din_o
);

	localparam cpu_addr_t ZP_BASE [4] = '{
		`ZP_END_PTR0, `ZP_END_PTR1, `ZP_END_PTR2, `ZP_END_PTR3
	};

	cpu_addr_t ptr [4];
	logic [3:0] lo_hit;
	logic [3:0] hi_hit;
	logic cas_q;
	logic zp_stb;
	byte_t ovl;

	// decode and overlay
	always_comb begin
		ovl = rd_byte_i;
		for (int i = 0; i < 4; i++) begin
			lo_hit[i] = c16_req_i.addr == ZP_BASE[i];
			hi_hit[i] = c16_req_i.addr == ZP_BASE[i] + 16'd1;
			if (lo_hit[i])
				ovl = ptr[i][7:0];
			if (hi_hit[i])
				ovl = ptr[i][15:8];
		end
	end

	assign c16_din_o = c16_req_i.rd ? ovl : rd_byte_i;

	// write strobe one cycle after cas fall, address is settled by then
	always_ff @(posedge clk28) begin
		if (reset) begin
			cas_q <= 1'b1;
			zp_stb <= 1'b0;
			for (int i = 0; i < 4; i++)
				ptr[i] <= '0;
		end else begin
			cas_q <= c16_cas_n_i;
			zp_stb <= cas_q & ~c16_cas_n_i;
			if (prg_done_i) begin
				for (int i = 0; i < 4; i++)
					ptr[i] <= end_addr_i;
			end else if (zp_stb && c16_req_i.wr) begin
				for (int i = 0; i < 4; i++) begin
					if (lo_hit[i])
						ptr[i][7:0] <= c16_req_i.wdata;
					if (hi_hit[i])
						ptr[i][15:8] <= c16_req_i.wdata;
				end
			end
		end
	end

endmodule

// File: verilog/tap_fetch.sv
`timescale 1ns/1ns
`include "c16_mem_macros.svh"

module tap_fetch import c16_mem_pkg::*; (
	input  logic     clk28,
	input  logic     reset,
	input  logic     tap_restart_i,
	input  io_addr_t tap_end_i,
	input  logic     ioctl_download_i,
	input  logic     slot_io_start_i,
	input  logic     slot_c16_start_i,
	input  byte_t    io_rd_byte_i,
	input  logic     tap_wrfull_i,
	output io_req_t  tap_req_o,
	output byte_t    tap_data_o,
	output logic     tap_wrreq_o
);

	io_addr_t ptr;
	logic rd_lvl;
	logic held;

	always_ff @(posedge clk28) begin
		if (reset) begin
			ptr <= `TAP_MEM_START;
			rd_lvl <= 1'b0;
			held <= 1'b0;
		end else begin
			if (tap_wrreq_o)
				held <= 1'b0;
			if (tap_restart_i) begin
				ptr <= `TAP_MEM_START;
				rd_lvl <= 1'b0;
			end else begin
				// one read per io slot, only with room in the fifo
				if (slot_io_start_i && !ioctl_download_i && !held &&
				    ptr < tap_end_i && !tap_wrfull_i)
					rd_lvl <= 1'b1;
				if (slot_c16_start_i && rd_lvl) begin
					tap_data_o <= io_rd_byte_i;
					held <= 1'b1;
					rd_lvl <= 1'b0;
					ptr <= ptr + 25'd1;
				end
			end
		end
	end

	// strobe waits while the fifo is full
	assign tap_wrreq_o = held & ~tap_wrfull_i;

	assign tap_req_o.addr = ptr;
	assign tap_req_o.wdata = '0;
	assign tap_req_o.wr = 1'b0;
	assign tap_req_o.rd = rd_lvl;

endmodule

// File: verilog/sdram_slot_arbiter.sv
`timescale 1ns/1ns

module sdram_slot_arbiter import c16_mem_pkg::*; (
	input  logic     clk28,
	input  logic     clkref_i,
	input  logic     memory_16k_i,
	input  c16_req_t c16_req_i,
	input  io_req_t  ld_req_i,
	input  io_req_t  tap_req_i,
	input  word_t    sdram_dout_i,
	output sd_req_t  sd_req_o,
	output byte_t    c16_rd_byte_o,
	output byte_t    io_rd_byte_o
);

	sd_addr_t c16_map;
	logic a0;

	// 16k mode drops a14/a15 so the ram aliases four times
	assign c16_map = memory_16k_i ?
		{10'd0, c16_req_i.addr[13:7], 1'b0, c16_req_i.addr[6:1]} :
		{9'd0, c16_req_i.addr[15:1]};

	always_comb begin
		if (clkref_i) begin
			sd_req_o.addr = c16_map;
			sd_req_o.wdata = {c16_req_i.wdata, c16_req_i.wdata};
			sd_req_o.we = c16_req_i.wr;
			sd_req_o.oe = c16_req_i.rd;
			a0 = c16_req_i.addr[0];
		end else if (tap_req_i.rd) begin
			sd_req_o.addr = tap_req_i.addr[24:1];
			sd_req_o.wdata = {tap_req_i.wdata, tap_req_i.wdata};
			sd_req_o.we = tap_req_i.wr;
			sd_req_o.oe = 1'b1;
			a0 = tap_req_i.addr[0];
		end else begin
			sd_req_o.addr = ld_req_i.addr[24:1];
			sd_req_o.wdata = {ld_req_i.wdata, ld_req_i.wdata};
			sd_req_o.we = ld_req_i.wr;
			sd_req_o.oe = ld_req_i.rd;
			a0 = ld_req_i.addr[0];
		end
		sd_req_o.ds = {a0, ~a0};
	end

	// each side picks its own half of the returned word
	assign c16_rd_byte_o = c16_req_i.addr[0] ? sdram_dout_i[15:8] : sdram_dout_i[7:0];
	assign io_rd_byte_o = tap_req_i.addr[0] ? sdram_dout_i[15:8] : sdram_dout_i[7:0];

	a_io_no_collision: assert property (@(posedge clk28)
		ld_req_i.wr |-> !tap_req_i.rd);

endmodule

// File: verilog/c16_mem_glue.sv
`timescale 1ns/1ns

module c16_mem_glue import c16_mem_pkg::*; (
	input  logic     clk28,
	input  logic     reset,
	input  logic     c16_ras_n_i,
	input  logic     c16_cas_n_i,
	input  logic     c16_rw_i,
	input  byte_t    c16_a_i,
	input  byte_t    c16_dout_i,
	input  logic     ioctl_wr_i,
	input  io_addr_t ioctl_addr_i,
	input  byte_t    ioctl_data_i,
	input  byte_t    ioctl_index_i,
	input  logic     ioctl_download_i,
	input  logic     memory_16k_i,
	input  word_t    sdram_dout_i,
	input  logic     tap_wrfull_i,
	output sd_req_t  sd_req_o,
	output byte_t    c16_din_o,
	output byte_t    tap_data_o,
	output logic     tap_wrreq_o,
	output logic     c16_wait_o
);

	c16_req_t c16_req;
	io_req_t ld_req;
	io_req_t tap_req;
	io_addr_t tap_end;
	byte_t c16_rd_byte;
	byte_t io_rd_byte;
	logic clkref;
	logic slot_io_start;
	logic slot_c16_start;
	logic prg_done;
	logic tap_restart;

	c16_bus_latch i_bus_latch (
		.clk28            (clk28),
		.reset            (reset),
		.c16_ras_n_i      (c16_ras_n_i),
		.c16_cas_n_i      (c16_cas_n_i),
		.c16_rw_i         (c16_rw_i),
		.c16_a_i          (c16_a_i),
		.c16_dout_i       (c16_dout_i),
		.c16_req_o        (c16_req),
		.clkref_o         (clkref),
		.slot_io_start_o  (slot_io_start),
		.slot_c16_start_o (slot_c16_start)
	);

	// tape version feeds the deck, which lives outside this block
	prg_loader i_prg_loader (
		.clk28            (clk28),
		.reset            (reset),
		.ioctl_wr_i       (ioctl_wr_i),
		.ioctl_addr_i     (ioctl_addr_i),
		.ioctl_data_i     (ioctl_data_i),
		.ioctl_index_i    (ioctl_index_i),
		.ioctl_download_i (ioctl_download_i),
		.slot_io_start_i  (slot_io_start),
		.slot_c16_start_i (slot_c16_start),
		.ld_req_o         (ld_req),
		.prg_done_o       (prg_done),
		.tap_end_o        (tap_end),
		.tap_version_o    (),
		.tap_restart_o    (tap_restart),
		.c16_wait_o       (c16_wait_o)
	);

	zp_shadow i_zp_shadow (
		.clk28       (clk28),
		.reset       (reset),
		.c16_req_i   (c16_req),
		.c16_cas_n_i (c16_cas_n_i),
		.prg_done_i  (prg_done),
		.end_addr_i  (ld_req.addr[15:0]),
		.rd_byte_i   (c16_rd_byte),
		.c16_din_o   (c16_din_o)
	);

	tap_fetch i_tap_fetch (
		.clk28            (clk28),
		.reset            (reset),
		.tap_restart_i    (tap_restart),
		.tap_end_i        (tap_end),
		.ioctl_download_i (ioctl_download_i),
		.slot_io_start_i  (slot_io_start),
		.slot_c16_start_i (slot_c16_start),
		.io_rd_byte_i     (io_rd_byte),
		.tap_wrfull_i     (tap_wrfull_i),
		.tap_req_o        (tap_req),
		.tap_data_o       (tap_data_o),
		.tap_wrreq_o      (tap_wrreq_o)
	);

	sdram_slot_arbiter i_arbiter (
		.clk28         (clk28),
		.clkref_i      (clkref),
		.memory_16k_i  (memory_16k_i),
		.c16_req_i     (c16_req),
		.ld_req_i      (ld_req),
		.tap_req_i     (tap_req),
		.sdram_dout_i  (sdram_dout_i),
		.sd_req_o      (sd_req_o),
		.c16_rd_byte_o (c16_rd_byte),
		.io_rd_byte_o  (io_rd_byte)
	);

endmodule

// File: testbench/c16_mem_checker.sv
`timescale 1ns/1ns

module c16_mem_checker import c16_mem_pkg::*; (
	input  logic  clk28,
	input  logic  reset,
	input  logic  prg_active_i,
	input  logic  c16_wait_i,
	input  logic  tap_wrreq_i,
	input  byte_t tap_data_i,
	input  logic  tap_wrfull_i,
	output int    errors_o,
	output logic  tape_empty_o
);

	byte_t tape_exp [$];
	int errors = 0;
	int tape_left = 0;

	task automatic check_byte(input string name, input byte_t got, input byte_t exp);
		if (got !== exp) begin
			errors++;
			$display("[ERROR] %0t %s got %02h expected %02h", $time, name, got, exp);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			errors++;
			$display("[ERROR] %0t %s got %0b expected %0b", $time, name, got, exp);
		end
	endtask

	task automatic push_tape(input byte_t b);
		tape_exp.push_back(b);
		tape_left++;
	endtask

	// --------------------
	// continuous port checks
	always @(posedge clk28) begin
		byte_t exp;
		if (!reset) begin
			// wait is up for the whole prg download
			check_bit("c16_wait_o", c16_wait_i, prg_active_i);
			if (tap_wrfull_i)
				check_bit("tap_wrreq_o", tap_wrreq_i, 1'b0);
			if (tap_wrreq_i) begin
				if (tape_left == 0) begin
					errors++;
					$display("tape byte %02h was delivered with no byte left to expect",
						tap_data_i);
				end else begin
					exp = tape_exp.pop_front();
					tape_left--;
					check_byte("tap_data_o", tap_data_i, exp);
				end
			end
		end
	end

	assign errors_o = errors;
	assign tape_empty_o = (tape_left == 0);

endmodule

// File: testbench/tb_c16_mem_glue.sv
`timescale 1ns/1ns
`include "c16_mem_macros.svh"

module tb_c16_mem_glue import c16_mem_pkg::*; ();

	logic clk28;
	logic reset = 1'b1;
	logic c16_ras_n_i;
	logic c16_cas_n_i;
	logic c16_rw_i;
	byte_t c16_a_i;
	byte_t c16_dout_i;
	logic ioctl_wr_i;
	io_addr_t ioctl_addr_i;
	byte_t ioctl_data_i;
	byte_t ioctl_index_i;
	logic ioctl_download_i;
	logic memory_16k_i;
	word_t sdram_dout_i;
	logic tap_wrfull_i;
	sd_req_t sd_req_o;
	byte_t c16_din_o;
	byte_t tap_data_o;
	logic tap_wrreq_o;
	logic c16_wait_o;

	int errors;
	int stim_errors = 0;
	logic tape_empty;
	logic timed_out = 1'b0;
	logic prg_active = 1'b0;

	// cpu request handed to the bus process, 0 idle 1 asked 2 running
	int cpu_state = 0;
	logic cpu_wr;
	cpu_addr_t cpu_addr;
	byte_t cpu_data;
	byte_t cpu_exp;

	word_t mem [0:131071];
	int dl_cnt;
	logic dl_prg;
	cpu_addr_t load_addr;
	cpu_addr_t prg_addr [$];
	byte_t prg_val [$];

	c16_mem_glue i_dut (.*);

	c16_mem_checker i_chk (
		.clk28        (clk28),
		.reset        (reset),
		.prg_active_i (prg_active),
		.c16_wait_i   (c16_wait_o),
		.tap_wrreq_i  (tap_wrreq_o),
		.tap_data_i   (tap_data_o),
		.tap_wrfull_i (tap_wrfull_i),
		.errors_o     (errors),
		.tape_empty_o (tape_empty)
	);

	initial begin
		clk28 = 1'b0;
		forever #20 clk28 = ~clk28;
	end

	// --------------------
	// sdram model, read word one edge later
	always @(posedge clk28) begin
		if (sd_req_o.we) begin
			if (sd_req_o.ds[0])
				mem[sd_req_o.addr[16:0]][7:0] <= sd_req_o.wdata[7:0];
			if (sd_req_o.ds[1])
				mem[sd_req_o.addr[16:0]][15:8] <= sd_req_o.wdata[15:8];
		end
		if (sd_req_o.oe)
			sdram_dout_i <= mem[sd_req_o.addr[16:0]];
	end

	// fifo full flag toggles at random
	initial begin
		int seed_ret;
		seed_ret = $urandom(75);
		forever begin
			@(negedge clk28);
			tap_wrfull_i = ($urandom % 3) == 0;
		end
	end

	// --------------------
	// c16 bus cycles, idle reads at 0000 when no request waits
	initial begin : c16_bus
		logic cur_own;
		logic cur_wr;
		cpu_addr_t cur_addr;
		byte_t cur_data;
		int t;
		for (t = 0; t < 16 && reset; t++)
			@(negedge clk28);
		if (reset)
			report_timeout("release of reset");
		forever begin
			@(negedge clk28);
			cur_own = (cpu_state == 1);
			cur_wr = cur_own ? cpu_wr : 1'b0;
			cur_addr = cur_own ? cpu_addr : 16'h0000;
			cur_data = cur_own ? cpu_data : 8'h00;
			if (cur_own)
				cpu_state = 2;
			c16_cas_n_i = 1'b1;
			c16_rw_i = 1'b1;
			c16_ras_n_i = 1'b0;
			c16_a_i = cur_addr[7:0];
			repeat (8) @(negedge clk28);
			c16_cas_n_i = 1'b0;
			c16_a_i = cur_addr[15:8];
			c16_rw_i = ~cur_wr;
			c16_dout_i = cur_data;
			repeat (7) @(negedge clk28);
			if (cur_own && !cur_wr)
				i_chk.check_byte($sformatf("c16_din_o at %04h", cur_addr), c16_din_o, cpu_exp);
			c16_ras_n_i = 1'b1;
			if (cur_own)
				cpu_state = 0;
		end
	end

	task automatic report_timeout(input string what);
		$display("timeout: %s never came", what);
		timed_out = 1'b1;
	endtask

	task automatic cpu_access(input logic wr, input cpu_addr_t addr, input byte_t data);
		int t;
		@(posedge clk28);
		cpu_wr = wr;
		cpu_addr = addr;
		cpu_data = data;
		cpu_exp = data;
		cpu_state = 1;
		for (t = 0; t < 64 && cpu_state != 0; t++)
			@(posedge clk28);
		if (cpu_state != 0)
			report_timeout("end of the c16 bus cycle");
	endtask

	task automatic start_download(input byte_t idx);
		@(negedge clk28);
		ioctl_index_i = idx;
		ioctl_download_i = 1'b1;
		prg_active = (idx == `IDX_PRG);
		dl_cnt = 0;
		dl_prg = (idx == `IDX_PRG);
		repeat (16) @(negedge clk28);
	endtask

	// one byte per slot pair
	task automatic send_byte(input byte_t b);
		@(negedge clk28);
		ioctl_wr_i = 1'b1;
		ioctl_data_i = b;
		ioctl_addr_i = io_addr_t'(dl_cnt);
		@(negedge clk28);
		ioctl_wr_i = 1'b0;
		if (dl_prg) begin
			if (dl_cnt == 0)
				load_addr[7:0] = b;
			else if (dl_cnt == 1)
				load_addr[15:8] = b;
			else begin
				prg_addr.push_back(load_addr + cpu_addr_t'(dl_cnt - 2));
				prg_val.push_back(b);
			end
		end
		dl_cnt++;
		repeat (15) @(negedge clk28);
	endtask

	task automatic wait_tape_drained();
		int t;
		for (t = 0; t < 4000 && !tape_empty; t++)
			@(posedge clk28);
		if (!tape_empty)
			report_timeout("last expected tape byte");
	endtask

	initial begin
		int fd;
		int n;
		int i;
		string line;
		byte_t cmd;
		logic [15:0] f1;
		logic [15:0] f2;
		word_t w;
		c16_ras_n_i = 1'b1;
		c16_cas_n_i = 1'b1;
		c16_rw_i = 1'b1;
		c16_a_i = '0;
		c16_dout_i = '0;
		ioctl_wr_i = 1'b0;
		ioctl_addr_i = '0;
		ioctl_data_i = '0;
		ioctl_index_i = '0;
		ioctl_download_i = 1'b0;
		memory_16k_i = 1'b0;
		sdram_dout_i = '0;
		tap_wrfull_i = 1'b0;
		for (i = 0; i < 131072; i++)
			mem[i] = word_t'(i ^ (i >> 9));
		repeat (3) @(negedge clk28);
		reset = 1'b0;

		fd = $fopen("testbench/c16_mem_input.txt", "r");
		if (fd == 0) begin
			$display("could not open the stimulus file");
			stim_errors++;
		end
		while (fd != 0 && !timed_out && $fgets(line, fd) > 0) begin
			n = $sscanf(line, "%c %h %h", cmd, f1, f2);
			if (n == 3 && cmd != "#") begin
				case (cmd)
					"P": start_download(`IDX_PRG);
					"T": start_download(`IDX_TAP);
					"B": send_byte(f2[7:0]);
					"E": begin
						@(negedge clk28);
						ioctl_download_i = 1'b0;
						prg_active = 1'b0;
						repeat (48) @(negedge clk28);
					end
					"W": cpu_access(1'b1, f1, f2[7:0]);
					"R": cpu_access(1'b0, f1, f2[7:0]);
					"M": begin
						@(negedge clk28);
						memory_16k_i = f2[0];
					end
					"Q": i_chk.push_tape(f2[7:0]);
					"F": wait_tape_drained();
					default: begin
						$display("unknown command in line: %s", line);
						stim_errors++;
					end
				endcase
			end
		end

		// prg bytes sit at load address plus index
		for (i = 0; i < prg_addr.size(); i++) begin
			w = mem[17'(prg_addr[i] >> 1)];
			i_chk.check_byte($sformatf("sdram byte %04h", prg_addr[i]),
				prg_addr[i][0] ? w[15:8] : w[7:0], prg_val[i]);
		end

		@(posedge clk28);
		$display("run complete: %0d errors, %0d timeouts, %0d stimulus errors",
			errors, timed_out ? 1 : 0, stim_errors);
		if (errors == 0 && !timed_out && stim_errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

// File: testbench/c16_mem_input.txt
# cmd field1 field2, fields in hex
# P/T start download, B byte, E end, W/R cpu write/read, M 16k, Q tape byte, F drain
P 0 0
B 0 01
B 0 10
B 0 a9
B 0 00
B 0 8d
B 0 20
E 0 0
R 2d 05
R 2e 10
R 2f 05
R 30 10
R 31 05
R 32 10
R 9d 05
R 9e 10
W 2f aa
R 2f aa
W 3000 5a
R 3000 5a
W c123 a5
R c123 a5
M 0 1
W 0456 3c
R 4456 3c
M 0 0
T 0 0
B 0 43
B 0 31
B 0 36
B 0 54
B 0 41
B 0 50
Q 0 43
Q 0 31
Q 0 36
Q 0 54
Q 0 41
Q 0 50
E 0 0
F 0 0

// File: tb.f
+incdir+verilog
verilog/c16_mem_pkg.sv
verilog/c16_bus_latch.sv
verilog/prg_loader.sv
verilog/zp_shadow.sv
verilog/tap_fetch.sv
verilog/sdram_slot_arbiter.sv
verilog/c16_mem_glue.sv
testbench/c16_mem_checker.sv
testbench/tb_c16_mem_glue.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f tb.f \
	--top-module tb_c16_mem_glue -Mdir obj_dir -o vtb
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/vtb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "Finished with no errors" "$LOG"; then
	exit 0
fi
exit 1
